/* tb.f */
source/sdramMemPkg.sv
source/sdramCmdPkg.sv
source/sdramControl.sv
source/casPipeline.sv
source/burstEngine.sv
source/sdramDataPath.sv
source/sdramModel.sv
bench/sdramModel_sva.sv
bench/sdramModelTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the SDRAM model testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module sdramModelTb -f tb.f -o simTb

./obj_dir/simTb | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi

/* bench/sdramModelTb.sv */
// Testbench with clock, reset, LFSR data, command tasks, shadow memory and checks

`timescale 1ns/1ps

module sdramModelTb
    import sdramMemPkg::*;
    import sdramCmdPkg::*;
();

    // Well above the roughly 130 cycles of stimulus
    localparam int maxCycles = 2000;
    localparam int noBeat = 99;

    logic Clk;
    logic rstN;
    logic csN;
    logic rasN;
    logic casN;
    logic weN;
    bankT ba;
    logic [addrBits-1:0] addr;
    byteMaskT dqm;
    dataT dqIn;
    dataT dqOut;
    byteMaskT dqOe;

    int edgeCnt = 0;
    int errCount = 0;
    logic [15:0] lfsr = 16'd19852;

    // Device state as tracked by the testbench
    int tbBl;
    int tbCl;
    bit tbInter;
    bit tbSingle;
    bit tbOpen [numBanks];
    int tbRow [numBanks];

    // Shadow array and expected read words keyed by edge number
    dataT shadow [int];
    dataT expWord [int];
    byteMaskT expLanes [int];
    dataT expDataNow;
    byteMaskT expOeNow;

    sdramModel #(
        .arrayRowBits (4),
        .arrayColBits (5)
    ) i_sdramModel (
        .Clk   (Clk),
        .rstN  (rstN),
        .csN   (csN),
        .rasN  (rasN),
        .casN  (casN),
        .weN   (weN),
        .ba    (ba),
        .addr  (addr),
        .dqm   (dqm),
        .dqIn  (dqIn),
        .dqOut (dqOut),
        .dqOe  (dqOe)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        edgeCnt <= edgeCnt + 1;
    end

    // Expected pins after this edge are stable by the falling edge
    always @(posedge Clk) begin
        if (expLanes.exists(edgeCnt + 1)) begin
            expOeNow <= expLanes[edgeCnt + 1];
            expDataNow <= expWord[edgeCnt + 1];
        end else begin
            expOeNow <= '0;
        end
    end

    always @(posedge Clk) begin
        if (edgeCnt >= maxCycles) begin
            $display("Timeout: stimulus did not finish within %0d cycles", maxCycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ****************************************
    // Read data checks
    // ****************************************

    oeCheck: assert property (@(negedge Clk) disable iff (!rstN) dqOe == expOeNow)
        else begin
            errCount++;
            $display("ERROR: dqOe expected %h actual %h after edge %0d",
                expOeNow, dqOe, edgeCnt);
        end

    dataCheck: assert property (@(negedge Clk) disable iff (!rstN)
        (expOeNow == '0) || (dqOut == expDataNow))
        else begin
            errCount++;
            $display("ERROR: dqOut expected %h actual %h after edge %0d",
                expDataNow, dqOut, edgeCnt);
        end

    // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic logic [3:0] pinCode(input cmdT c);
        case (c)
            ACTIVE: return 4'b0011;
            READ: return 4'b0101;
            WRITE: return 4'b0100;
            PRECHARGE: return 4'b0010;
            BURST_TERM: return 4'b0110;
            LOAD_MODE: return 4'b0000;
            default: return 4'b0111;
        endcase
    endfunction

    // Column of a beat wrapping inside the burst-length window
    function automatic int beatCol(input int start, input int beat, input int len,
                                   input bit inter);
        int low;
        if (inter) begin
            low = (start ^ beat) % len;
        end else begin
            low = (start + beat) % len;
        end
        return start - (start % len) + low;
    endfunction

    function automatic int memKey(input int b, input int row, input int col);
        return (b << 24) | (row << 10) | col;
    endfunction

    task automatic randWord(output dataT w);
        w = '0;
        for (int i = 0; i < dataBits; i++) begin
            w = {w[dataBits-2:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
    endtask

    task automatic nextEdge();
        @(posedge Clk);
        #1;
    endtask

    // Drives the pins for the coming edge and tracks bank state
    task automatic sendCommand(input cmdT c, input int b, input int a);
        {csN, rasN, casN, weN} = pinCode(c);
        ba = bankT'(b);
        addr = addrBits'(a);
        if ((c == ACTIVE) && !tbOpen[b]) begin
            tbOpen[b] = 1'b1;
            tbRow[b] = a;
        end
        if (c == PRECHARGE) begin
            if (a[allBanksBit]) begin
                foreach (tbOpen[i]) begin
                    tbOpen[i] = 1'b0;
                end
            end else begin
                tbOpen[b] = 1'b0;
            end
        end
    endtask

    task automatic loadMode(input int blCode, input bit inter, input int cl,
                            input bit single);
        modeRegT m;
        m = '0;
        m.burstLen = 3'(blCode);
        m.burstType = inter;
        m.casLat = 3'(cl);
        m.writeSingle = single;
        sendCommand(LOAD_MODE, 0, int'(m));
        nextEdge();
        tbBl = 1 << blCode;
        tbInter = inter;
        tbCl = cl;
        tbSingle = single;
    endtask

    task automatic openRow(input int b, input int row);
        sendCommand(ACTIVE, b, row);
        nextEdge();
    endtask

    // Full burst of random data that stopCmd may cut at beat stopAt
    task automatic writeBurst(input int b, input int col, input byteMaskT mask,
                              input int stopAt, input cmdT stopCmd);
        dataT word;
        dataT cur;
        int stored;
        int key;
        bit bankWasOpen;
        bankWasOpen = tbOpen[b];
        stored = tbSingle ? 1 : tbBl;
        if (stopAt < stored) begin
            stored = stopAt;
        end
        for (int i = 0; i < tbBl; i++) begin
            randWord(word);
            dqIn = word;
            dqm = mask;
            if (i == 0) begin
                sendCommand(WRITE, b, col);
            end else if (i == stopAt) begin
                sendCommand(stopCmd, b, 0);
            end else begin
                sendCommand(NOP, 0, 0);
            end
            if (bankWasOpen && (i < stored)) begin
                key = memKey(b, tbRow[b], beatCol(col, i, tbBl, tbInter));
                cur = shadow.exists(key) ? shadow[key] : '0;
                for (int lane = 0; lane < byteLanes; lane++) begin
                    if (!mask[lane]) begin
                        cur[lane*laneBits +: laneBits] = word[lane*laneBits +: laneBits];
                    end
                end
                shadow[key] = cur;
            end
            nextEdge();
        end
        sendCommand(NOP, 0, 0);
        dqm = '0;
    endtask

    // Upper lane masked from edge k+maskFrom and BURST_TERM at edge k+termAt
    task automatic readBurst(input int b, input int col, input int maskFrom,
                             input int termAt);
        int k;
        int key;
        k = edgeCnt + 1;
        if (tbOpen[b]) begin
            for (int i = 0; i < tbBl && i < termAt; i++) begin
                key = memKey(b, tbRow[b], beatCol(col, i, tbBl, tbInter));
                expWord[k + tbCl + i] = shadow[key];
                expLanes[k + tbCl + i] = (tbCl + i - 2 >= maskFrom) ? 2'b01 : 2'b11;
            end
        end
        for (int s = 0; s <= tbCl + tbBl; s++) begin
            dqm = (s >= maskFrom) ? 2'b10 : 2'b00;
            if (s == 0) begin
                sendCommand(READ, b, col);
            end else if (s == termAt) begin
                sendCommand(BURST_TERM, 0, 0);
            end else begin
                sendCommand(NOP, 0, 0);
            end
            nextEdge();
        end
        dqm = '0;
    endtask

    // ****************************************
    // Stimulus
    // ****************************************

    initial begin
        rstN = 1'b0;
        csN = 1'b1;
        rasN = 1'b1;
        casN = 1'b1;
        weN = 1'b1;
        ba = '0;
        addr = '0;
        dqm = '0;
        dqIn = '0;
        tbBl = 1;
        tbCl = 2;
        tbInter = 1'b0;
        tbSingle = 1'b0;
        foreach (tbOpen[i]) begin
            tbOpen[i] = 1'b0;
            tbRow[i] = 0;
        end
        repeat (2) @(posedge Clk);
        #1;
        rstN = 1'b1;
        nextEdge();

        // BL4 sequential CL2 with writes wrapping from col 1 and reads from col 2
        loadMode(2, 1'b0, 2, 1'b0);
        openRow(0, 3);
        writeBurst(0, 1, 2'b00, noBeat, NOP);
        readBurst(0, 2, noBeat, noBeat);

        // BL8 interleaved CL3 with an odd start column
        loadMode(3, 1'b1, 3, 1'b0);
        openRow(1, 5);
        writeBurst(1, 0, 2'b00, noBeat, NOP);
        readBurst(1, 5, noBeat, noBeat);

        // Upper byte kept on masked write and read DQM raised mid burst
        loadMode(2, 1'b0, 2, 1'b0);
        writeBurst(1, 8, 2'b00, noBeat, NOP);
        writeBurst(1, 8, 2'b10, noBeat, NOP);
        readBurst(1, 8, 2, noBeat);

        // Read termination, write cut by precharge and single-word writes
        readBurst(1, 8, noBeat, 2);
        writeBurst(1, 12, 2'b00, noBeat, NOP);
        writeBurst(1, 12, 2'b00, 2, PRECHARGE);
        openRow(1, 5);
        readBurst(1, 12, noBeat, noBeat);
        writeBurst(1, 16, 2'b00, noBeat, NOP);
        loadMode(2, 1'b0, 2, 1'b1);
        writeBurst(1, 16, 2'b00, noBeat, NOP);
        loadMode(2, 1'b0, 2, 1'b0);
        readBurst(1, 16, noBeat, noBeat);

        // Closed banks after precharge all through A10
        openRow(2, 2);
        openRow(3, 7);
        writeBurst(2, 0, 2'b00, noBeat, NOP);
        sendCommand(PRECHARGE, 0, 1 << allBanksBit);
        nextEdge();
        readBurst(2, 0, noBeat, noBeat);
        readBurst(3, 0, noBeat, noBeat);
        writeBurst(2, 0, 2'b00, noBeat, NOP);
        openRow(2, 2);
        readBurst(2, 0, noBeat, noBeat);

        repeat (4) @(posedge Clk);
        $display("Run finished after %0d cycles with %0d errors", edgeCnt, errCount);
        if (errCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* bench/sdramModel_sva.sv */
// Bound protocol assertions on the SDRAM model output enable

`timescale 1ns/1ps

module sdramModelSva
    import sdramMemPkg::*;
(
    input logic Clk,
    input logic rstN,
    input byteMaskT dqm,
    input byteMaskT dqOe
);

    // Saturating count of edges since reset release
    logic [1:0] sinceReset;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            sinceReset <= '0;
        end else if (sinceReset != 2'd3) begin
            sinceReset <= sinceReset + 2'd1;
        end
    end

    // ****************************************
    // Output enable protocol
    // ****************************************

    // Pins stay released while reset is held
    resetQuiet: assert property (@(posedge Clk) !rstN |-> (dqOe == '0))
        else $error("dqOe driven while reset is asserted");

    // Even a READ right after reset needs CL edges to reach the pins
    startQuiet: assert property (@(posedge Clk) disable iff (!rstN)
        (sinceReset != 2'd3) |-> (dqOe == '0))
        else $error("dqOe driven in the first cycles after reset");

    // A driven lane had DQM low two edges before the word left the array
    laneUnmasked: assert property (@(posedge Clk) disable iff (!rstN)
        (dqOe & $past(dqm, 3)) == '0)
        else $error("dqOe lane driven although DQM masked it two edges earlier");

endmodule

bind sdramModel sdramModelSva i_sdramModelSva (
    .Clk  (Clk),
    .rstN (rstN),
    .dqm  (dqm),
    .dqOe (dqOe)
);

/* source/sdramModel.sv */
// Top level of the SDR SDRAM model connecting decoder, CAS pipe, burst engine and array

`timescale 1ns/1ps

module sdramModel
    import sdramMemPkg::*;
    import sdramCmdPkg::*;
#(
    parameter int arrayRowBits = 4,
    parameter int arrayColBits = 5
) (
    input  logic Clk,
    input  logic rstN,
    input  logic csN,
    input  logic rasN,
    input  logic casN,
    input  logic weN,
    input  bankT ba,
    input  logic [addrBits-1:0] addr,
    input  byteMaskT dqm,
    input  dataT dqIn,
    output dataT dqOut,
    output byteMaskT dqOe
);

    modeRegT mode;
    colCmdT issueCmd;
    logic issueValid;
    colCmdT writeCmd;
    logic writeValid;
    colCmdT pipeCmd;
    logic pipeValid;
    memAccessT access;

    sdramControl i_sdramControl (
        .Clk        (Clk),
        .rstN       (rstN),
        .csN        (csN),
        .rasN       (rasN),
        .casN       (casN),
        .weN        (weN),
        .ba         (ba),
        .addr       (addr),
        .mode       (mode),
        .issueCmd   (issueCmd),
        .issueValid (issueValid),
        .writeCmd   (writeCmd),
        .writeValid (writeValid)
    );

    // Read path delayed by CAS latency
    casPipeline i_casPipeline (
        .Clk        (Clk),
        .rstN       (rstN),
        .mode       (mode),
        .issueCmd   (issueCmd),
        .issueValid (issueValid),
        .pipeCmd    (pipeCmd),
        .pipeValid  (pipeValid)
    );

    burstEngine i_burstEngine (
        .Clk        (Clk),
        .rstN       (rstN),
        .mode       (mode),
        .writeCmd   (writeCmd),
        .writeValid (writeValid),
        .pipeCmd    (pipeCmd),
        .pipeValid  (pipeValid),
        .access     (access)
    );

    sdramDataPath #(
        .arrayRowBits (arrayRowBits),
        .arrayColBits (arrayColBits)
    ) i_sdramDataPath (
        .Clk    (Clk),
        .rstN   (rstN),
        .access (access),
        .dqIn   (dqIn),
        .dqm    (dqm),
        .dqOut  (dqOut),
        .dqOe   (dqOe)
    );

endmodule

/* source/sdramDataPath.sv */
// Banked storage with byte-masked writes, registered reads and read DQM delay

`timescale 1ns/1ps

module sdramDataPath
    import sdramMemPkg::*;
#(
    parameter int arrayRowBits = 4,
    parameter int arrayColBits = 5
) (
    input  logic Clk,
    input  logic rstN,
    input  memAccessT access,
    input  dataT dqIn,
    input  byteMaskT dqm,
    output dataT dqOut,
    output byteMaskT dqOe
);

    localparam int indexBits = arrayRowBits + arrayColBits;
    localparam int depth = 1 << indexBits;

    // One array per bank, only low row and column bits are decoded
    dataT store [numBanks][depth];
    logic [indexBits-1:0] index;
    byteMaskT dqmD1;
    byteMaskT dqmD2;

    assign index = {access.row[arrayRowBits-1:0], access.col[arrayColBits-1:0]};

    // ****************************************
    // Array write and read
    // ****************************************

    always_ff @(posedge Clk) begin
        if (access.wrEn) begin
            for (int lane = 0; lane < byteLanes; lane++) begin
                // Write DQM has zero latency
                if (!dqm[lane]) begin
                    store[access.bank][index][lane*laneBits +: laneBits] <=
                        dqIn[lane*laneBits +: laneBits];
                end
            end
        end
        if (access.rdEn) begin
            dqOut <= store[access.bank][index];
        end
    end

    // ****************************************
    // Read DQM pipe and output enable
    // ****************************************

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            dqmD1 <= '0;
            dqmD2 <= '0;
            dqOe <= '0;
        end else begin
            dqmD1 <= dqm;
            dqmD2 <= dqmD1;
            // Lane enable uses DQM from two edges back
            if (access.rdEn) begin
                dqOe <= ~dqmD2;
            end else begin
                dqOe <= '0;
            end
        end
    end

endmodule

/* source/burstEngine.sv */
// Burst sequencer producing one array access per cycle for reads and writes

`timescale 1ns/1ps

module burstEngine
    import sdramMemPkg::*;
    import sdramCmdPkg::*;
(
    input  logic Clk,
    input  logic rstN,
    input  modeRegT mode,
    input  colCmdT writeCmd,
    input  logic writeValid,
    input  colCmdT pipeCmd,
    input  logic pipeValid,
    output memAccessT access
);

    bankT burstBank;
    logic [addrBits-1:0] burstRow;
    logic [colBusBits-1:0] startCol;
    logic [colBusBits-1:0] curCol;
    logic [beatBits-1:0] beatCnt;
    logic [beatBits-1:0] nextCnt;
    logic [beatBits-1:0] beats;
    logic reading;
    logic writing;
    logic startWrite;
    logic startRead;
    logic stopWrite;
    logic stopRead;
    colCmdT startCmd;

    // Column of beat cnt inside the aligned burst window
    function automatic logic [colBusBits-1:0] burstCol(
        input logic [colBusBits-1:0] base,
        input logic [beatBits-1:0] cnt,
        input logic [beatBits-1:0] len,
        input logic interleaved
    );
        logic [colBusBits-1:0] mask;
        logic [colBusBits-1:0] offs;
        mask = colBusBits'(len - 1'b1);
        if (interleaved) begin
            offs = base ^ colBusBits'(cnt);
        end else begin
            offs = base + colBusBits'(cnt);
        end
        return (base & ~mask) | (offs & mask);
    endfunction

    assign beats = burstBeats(mode);
    assign nextCnt = beatCnt + 1'b1;

    // ****************************************
    // Command arrival
    // ****************************************

    // The newest command wins when a write meets a piped read
    assign startWrite = writeValid && (writeCmd.kind == WRITE);
    assign startRead = pipeValid && (pipeCmd.kind == READ) && !startWrite;

    assign stopWrite = writeValid && ((writeCmd.kind == BURST_TERM) ||
        ((writeCmd.kind == PRECHARGE) && (writeCmd.allBanks || writeCmd.bank == burstBank)));
    assign stopRead = pipeValid && ((pipeCmd.kind == BURST_TERM) ||
        ((pipeCmd.kind == PRECHARGE) && (pipeCmd.allBanks || pipeCmd.bank == burstBank)));

    assign startCmd = startWrite ? writeCmd : pipeCmd;

    // First beat takes its address straight from the command
    always_comb begin
        access = '0;
        if (startWrite || startRead) begin
            access.bank = startCmd.bank;
            access.row = startCmd.row;
            access.col = startCmd.col;
            access.wrEn = startWrite;
            access.rdEn = startRead;
        end else if ((writing && !stopWrite) || (reading && !stopRead)) begin
            access.bank = burstBank;
            access.row = burstRow;
            access.col = curCol;
            access.wrEn = writing;
            access.rdEn = reading;
        end
    end

    // ****************************************
    // Burst state
    // ****************************************

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            reading <= 1'b0;
            writing <= 1'b0;
            beatCnt <= '0;
        end else if (startWrite || startRead) begin
            beatCnt <= beatBits'(1);
            writing <= startWrite && (beats != beatBits'(1)) && !mode.writeSingle;
            reading <= startRead && (beats != beatBits'(1));
        end else if (access.wrEn || access.rdEn) begin
            beatCnt <= nextCnt;
            if (nextCnt >= beats) begin
                reading <= 1'b0;
                writing <= 1'b0;
            end
        end else begin
            if (stopWrite) begin
                writing <= 1'b0;
            end
            if (stopRead) begin
                reading <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (startWrite || startRead) begin
            burstBank <= startCmd.bank;
            burstRow <= startCmd.row;
            startCol <= startCmd.col;
            curCol <= burstCol(startCmd.col, beatBits'(1), beats, mode.burstType);
        end else if (access.wrEn || access.rdEn) begin
            curCol <= burstCol(startCol, nextCnt, beats, mode.burstType);
        end
    end

endmodule

/* source/casPipeline.sv */
// CAS latency shift line for read and read termination commands

`timescale 1ns/1ps

module casPipeline
    import sdramCmdPkg::*;
(
    input  logic Clk,
    input  logic rstN,
    input  modeRegT mode,
    input  colCmdT issueCmd,
    input  logic issueValid,
    output colCmdT pipeCmd,
    output logic pipeValid
);

    localparam int slotIdxBits = $clog2(maxCasLat);

    colCmdT slotCmd [maxCasLat];
    logic [maxCasLat-1:0] slotValid;
    logic [slotIdxBits-1:0] insSlot;

    // Slot 0 is presented after casLat-1 more edges
    always_comb begin
        if (mode.casLat >= 3'(maxCasLat)) begin
            insSlot = slotIdxBits'(maxCasLat - 1);
        end else if (mode.casLat <= 3'd1) begin
            insSlot = '0;
        end else begin
            insSlot = slotIdxBits'(mode.casLat - 3'd1);
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            slotValid <= '0;
        end else begin
            slotValid <= {1'b0, slotValid[maxCasLat-1:1]};
            if (issueValid) begin
                slotValid[insSlot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        for (int i = 0; i < maxCasLat - 1; i++) begin
            slotCmd[i] <= slotCmd[i+1];
        end
        if (issueValid) begin
            slotCmd[insSlot] <= issueCmd;
        end
    end

    assign pipeCmd = slotCmd[0];
    assign pipeValid = slotValid[0];

endmodule

/* source/sdramControl.sv */
// Command decoder, mode register and per-bank open/row table

`timescale 1ns/1ps

module sdramControl
    import sdramMemPkg::*;
    import sdramCmdPkg::*;
(
    input  logic Clk,
    input  logic rstN,
    input  logic csN,
    input  logic rasN,
    input  logic casN,
    input  logic weN,
    input  bankT ba,
    input  logic [addrBits-1:0] addr,
    output modeRegT mode,
    output colCmdT issueCmd,
    output logic issueValid,
    output colCmdT writeCmd,
    output logic writeValid
);

    cmdT cmd;
    colCmdT colCmd;
    logic [numBanks-1:0] bankOpen;
    logic [addrBits-1:0] bankRow [numBanks];
    logic targetOpen;
    logic termCmd;

    // ****************************************
    // Pin decode
    // ****************************************

    always_comb begin
        if (csN) begin
            cmd = NOP;
        end else begin
            case ({rasN, casN, weN})
                3'b011: cmd = ACTIVE;
                3'b101: cmd = READ;
                3'b100: cmd = WRITE;
                3'b010: cmd = PRECHARGE;
                3'b110: cmd = BURST_TERM;
                3'b000: cmd = LOAD_MODE;
                // Auto refresh and NOP
                default: cmd = NOP;
            endcase
        end
    end

    assign targetOpen = bankOpen[ba];
    assign termCmd = (cmd == PRECHARGE) || (cmd == BURST_TERM);

    // Row comes from the bank table for READ and WRITE
    always_comb begin
        colCmd.kind = cmd;
        colCmd.bank = ba;
        colCmd.row = bankRow[ba];
        colCmd.col = addr[colBusBits-1:0];
        colCmd.allBanks = addr[allBanksBit];
    end

    // Reads and terminations go through the CAS pipeline
    assign issueCmd = colCmd;
    assign issueValid = ((cmd == READ) && targetOpen) || termCmd;

    // Writes and terminations act at once
    assign writeCmd = colCmd;
    assign writeValid = ((cmd == WRITE) && targetOpen) || termCmd;

    // ****************************************
    // Mode register and bank state
    // ****************************************

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            mode <= modeReset;
            bankOpen <= '0;
        end else begin
            if (cmd == LOAD_MODE) begin
                mode <= modeRegT'(addr);
            end
            if ((cmd == ACTIVE) && !targetOpen) begin
                bankOpen[ba] <= 1'b1;
            end
            if (cmd == PRECHARGE) begin
                if (addr[allBanksBit]) begin
                    bankOpen <= '0;
                end else begin
                    bankOpen[ba] <= 1'b0;
                end
            end
        end
    end

    // Row latch, only valid while the bank is open
    always_ff @(posedge Clk) begin
        if ((cmd == ACTIVE) && !targetOpen) begin
            bankRow[ba] <= addr;
        end
    end

endmodule

/* source/sdramCmdPkg.sv */
// Command encoding, mode register layout and pipelined column command type

package sdramCmdPkg;

    import sdramMemPkg::*;

    localparam int addrBits = rowAddrBits;
    localparam int colBusBits = colAddrBits;

    // A10 selects all banks on PRECHARGE
    localparam int allBanksBit = 10;

    localparam int maxCasLat = 3;
    localparam int maxBurst = 8;
    localparam int beatBits = $clog2(maxBurst) + 1;

    typedef enum logic [2:0] {
        NOP,
        ACTIVE,
        READ,
        WRITE,
        PRECHARGE,
        BURST_TERM,
        LOAD_MODE
    } cmdT;

    // Same bit order as the address pins at LOAD MODE REGISTER
    typedef struct packed {
        logic [2:0] reservedHigh;
        logic writeSingle;
        logic [1:0] opMode;
        logic [2:0] casLat;
        logic burstType;
        logic [2:0] burstLen;
    } modeRegT;

    localparam modeRegT modeReset = '{
        reservedHigh: 3'd0,
        writeSingle: 1'b0,
        opMode: 2'd0,
        casLat: 3'd2,
        burstType: 1'b0,
        burstLen: 3'd0
    };

    typedef struct packed {
        cmdT kind;
        bankT bank;
        logic [addrBits-1:0] row;
        logic [colBusBits-1:0] col;
        logic allBanks;
    } colCmdT;

    // Beats per burst, unsupported codes fall back to one beat
    function automatic logic [beatBits-1:0] burstBeats(input modeRegT m);
        if (m.burstLen[2]) begin
            return beatBits'(1);
        end
        return beatBits'(1) << m.burstLen[1:0];
    endfunction

endpackage

/* source/sdramMemPkg.sv */
// Data word, byte mask, bank and array access types for the SDRAM model

package sdramMemPkg;

    // Data bus
    localparam int dataBits = 16;
    localparam int byteLanes = 2;
    localparam int laneBits = dataBits / byteLanes;

    // Device geometry seen on the pins
    localparam int numBanks = 4;
    localparam int rowAddrBits = 13;
    localparam int colAddrBits = 10;

    typedef logic [dataBits-1:0] dataT;

    // A set bit masks that byte lane
    typedef logic [byteLanes-1:0] byteMaskT;

    typedef logic [$clog2(numBanks)-1:0] bankT;

    // One array access per cycle, read or write
    typedef struct packed {
        bankT bank;
        logic [rowAddrBits-1:0] row;
        logic [colAddrBits-1:0] col;
        logic wrEn;
        logic rdEn;
    } memAccessT;

endpackage
